/* design/rv_pkg.sv */
package rv_pkg;

  // memory map
  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam int dmem_words = 256;
  localparam int dmem_addr_bits = $clog2(dmem_words);
  localparam logic [31:0] dmem_base = 32'h0001_0000;

  // major opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // phase sequencer codes, 2'b11 unused
  localparam logic [1:0] phase_fetch = 2'd0;
  localparam logic [1:0] phase_mem = 2'd1;
  localparam logic [1:0] phase_wb = 2'd2;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;
  typedef enum logic {op_a_reg, op_a_pc} op_a_sel_e;
  typedef enum logic {op_b_reg, op_b_imm} op_b_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic imm_11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  // one instruction word, six ways to look at it
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_instr_u;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic reg_wen;
    logic mem_wen;
    logic mem_ren;
    logic [2:0] funct3;
    alu_op_e alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    wb_sel_e wb_sel;
    logic is_branch;
    logic is_jump;
    logic is_ecall;
  } rv_ctrl_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic rd_wen;
    logic [4:0] rd;
    logic [31:0] rd_data;
  } rv_retire_t;

endpackage

/* design/rv_regfile.sv */
module rv_regfile (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
    ((rs1 == 5'd0) |-> (rdata1 == 32'd0)) and ((rs2 == 5'd0) |-> (rdata2 == 32'd0)));

endmodule

/* design/rv_alu.sv */
module rv_alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  rv_pkg::alu_op_e op,
  input  logic [31:0]     rs1_data,
  input  logic [31:0]     rs2_data,
  input  logic [2:0]      funct3,
  output logic [31:0]     result,
  output logic            branch_taken
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:   result = {31'd0, a < b};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_pass_b: result = b;
      default:            result = 32'd0;
    endcase
  end

  // branch compare works on register data, not on the muxed operands
  assign equal = (rs1_data == rs2_data);
  assign lt_signed = $signed(rs1_data) < $signed(rs2_data);
  assign lt_unsigned = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = equal;
      3'b001:  branch_taken = !equal;
      3'b100:  branch_taken = lt_signed;
      3'b101:  branch_taken = !lt_signed;
      3'b110:  branch_taken = lt_unsigned;
      3'b111:  branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* design/rv_imm_gen.sv */
module rv_imm_gen (
  input  rv_pkg::rv_instr_u instr,
  output logic [31:0]       imm
);

  always_comb begin
    case (instr.r.opcode)
      rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_jalr: begin
        imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      rv_pkg::op_store: begin
        imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      rv_pkg::op_branch: begin
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      rv_pkg::op_lui, rv_pkg::op_auipc: begin
        imm = {instr.u.imm_31_12, 12'd0};
      end
      rv_pkg::op_jal: begin
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      // r-type and anything unknown
      default: imm = 32'd0;
    endcase
  end

endmodule

/* design/rv_data_mem.sv */
module rv_data_mem (
  input  logic        clk,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [2:0]  funct3,
  input  logic        ren,
  input  logic        wen,
  output logic [31:0] rdata
);

  logic [31:0] mem [rv_pkg::dmem_words];
  logic [31:0] offset;
  logic [rv_pkg::dmem_addr_bits-1:0] word_idx;
  logic [3:0] byte_en;
  logic [31:0] lane_data;
  logic [31:0] rd_word;
  logic [31:0] shifted;

  // wraps modulo the memory size
  assign offset = addr - rv_pkg::dmem_base;
  assign word_idx = offset[rv_pkg::dmem_addr_bits+1:2];

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        byte_en = 4'b0001 << offset[1:0];
        lane_data = {4{wdata[7:0]}};
      end
      2'b01: begin
        byte_en = 4'b0011 << offset[1:0];
        lane_data = {2{wdata[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;
        lane_data = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wen && byte_en[i]) begin
        mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
    if (ren) begin
      rd_word <= mem[word_idx];
    end
  end

  // addr and funct3 still hold the same instruction in the wb cycle
  assign shifted = rd_word >> {offset[1:0], 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  rdata = {{24{shifted[7]}}, shifted[7:0]};
      3'b001:  rdata = {{16{shifted[15]}}, shifted[15:0]};
      3'b100:  rdata = {24'd0, shifted[7:0]};
      3'b101:  rdata = {16'd0, shifted[15:0]};
      default: rdata = rd_word;
    endcase
  end

  a_aligned_write: assert property (@(posedge clk)
    wen |-> ((funct3[1:0] != 2'b01 || addr[0] == 1'b0)
             && (funct3[1:0] != 2'b10 || addr[1:0] == 2'b00)));

endmodule

/* design/rv_control.sv */
module rv_control (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [31:0]       imem_data,
  input  logic [31:0]       alu_out,
  input  logic              branch_taken,
  output rv_pkg::rv_ctrl_t  ctrl,
  output rv_pkg::rv_instr_u instr,
  output logic [31:0]       pc,
  output logic              mem_phase,
  output logic              wb_phase,
  output logic              retire_valid,
  output logic              halted
);

  logic [1:0] phase;
  logic fetch_phase;
  logic redirect;

  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: alu_decode = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001: alu_decode = rv_pkg::alu_sll;
      3'b010: alu_decode = rv_pkg::alu_slt;
      3'b011: alu_decode = rv_pkg::alu_sltu;
      3'b100: alu_decode = rv_pkg::alu_xor;
      3'b101: alu_decode = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110: alu_decode = rv_pkg::alu_or;
      default: alu_decode = rv_pkg::alu_and;
    endcase
  endfunction

  assign fetch_phase = (phase == rv_pkg::phase_fetch);
  assign mem_phase = (phase == rv_pkg::phase_mem);
  assign wb_phase = (phase == rv_pkg::phase_wb);
  assign retire_valid = wb_phase;

  // fetch -> mem -> wb, parked in fetch once halted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= rv_pkg::phase_fetch;
      instr <= '0;
    end else if (!halted) begin
      if (fetch_phase) begin
        instr <= imem_data;
      end
      phase <= wb_phase ? rv_pkg::phase_fetch : phase + 2'd1;
    end
  end

  assign redirect = ctrl.is_jump || (ctrl.is_branch && branch_taken);

  // jump targets drop bit 0, which only matters for jalr
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_pkg::reset_pc;
      halted <= 1'b0;
    end else if (wb_phase) begin
      pc <= redirect ? {alu_out[31:1], 1'b0} : pc + 32'd4;
      halted <= ctrl.is_ecall;
    end
  end

  always_comb begin
    ctrl.rs1 = instr.r.rs1;
    ctrl.rs2 = instr.r.rs2;
    ctrl.rd = instr.r.rd;
    ctrl.funct3 = instr.r.funct3;
    ctrl.reg_wen = 1'b0;
    ctrl.mem_wen = 1'b0;
    ctrl.mem_ren = 1'b0;
    ctrl.alu_op = rv_pkg::alu_add;
    ctrl.op_a_sel = rv_pkg::op_a_reg;
    ctrl.op_b_sel = rv_pkg::op_b_imm;
    ctrl.wb_sel = rv_pkg::wb_alu;
    ctrl.is_branch = 1'b0;
    ctrl.is_jump = 1'b0;
    ctrl.is_ecall = 1'b0;
    case (instr.r.opcode)
      rv_pkg::op_lui: begin
        ctrl.reg_wen = 1'b1;
        ctrl.alu_op = rv_pkg::alu_pass_b;
      end
      rv_pkg::op_auipc: begin
        ctrl.reg_wen = 1'b1;
        ctrl.op_a_sel = rv_pkg::op_a_pc;
      end
      rv_pkg::op_jal, rv_pkg::op_jalr: begin
        ctrl.reg_wen = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.wb_sel = rv_pkg::wb_pc_plus4;
        if (instr.r.opcode == rv_pkg::op_jal) begin
          ctrl.op_a_sel = rv_pkg::op_a_pc;
        end
      end
      rv_pkg::op_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.op_a_sel = rv_pkg::op_a_pc;
      end
      rv_pkg::op_load: begin
        ctrl.reg_wen = 1'b1;
        ctrl.mem_ren = 1'b1;
        ctrl.wb_sel = rv_pkg::wb_mem;
      end
      rv_pkg::op_store: ctrl.mem_wen = 1'b1;
      rv_pkg::op_imm: begin
        ctrl.reg_wen = 1'b1;
        // funct7 only means something for the right shifts
        ctrl.alu_op = alu_decode(instr.r.funct3,
                                 instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
      end
      rv_pkg::op_reg: begin
        ctrl.reg_wen = 1'b1;
        ctrl.op_b_sel = rv_pkg::op_b_reg;
        ctrl.alu_op = alu_decode(instr.r.funct3, instr.r.funct7[5]);
      end
      rv_pkg::op_system: begin
        ctrl.is_ecall = (instr.r.funct3 == 3'b000) && (instr.r.funct7 == 7'd0)
                        && (instr.r.rs2 == 5'd0);
      end
      default: ;
    endcase
  end

  a_phase_legal: assert property (@(posedge clk) disable iff (!arst_n) phase != 2'b11);
  a_no_retire_halted: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> !halted);

endmodule

/* design/rv_core.sv */
module rv_core (
  input  logic               clk,
  input  logic               arst_n,
  output logic [31:0]        imem_addr,
  input  logic [31:0]        imem_data,
  output rv_pkg::rv_retire_t retire,
  output logic               halted
);

  rv_pkg::rv_ctrl_t ctrl;
  rv_pkg::rv_instr_u instr;
  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic mem_phase;
  logic wb_phase;
  logic retire_valid;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic branch_taken;
  logic [31:0] mem_rdata;
  logic [31:0] wb_data;

  rv_control u_control (
    .clk, .arst_n, .imem_data, .alu_out, .branch_taken,
    .ctrl, .instr, .pc, .mem_phase, .wb_phase, .retire_valid, .halted
  );

  rv_regfile u_regfile (
    .clk, .arst_n,
    .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
    .wen(wb_phase && ctrl.reg_wen), .wdata(wb_data),
    .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_imm_gen u_imm_gen (.instr, .imm);

  assign op_a = (ctrl.op_a_sel == rv_pkg::op_a_pc) ? pc : rs1_data;
  assign op_b = (ctrl.op_b_sel == rv_pkg::op_b_imm) ? imm : rs2_data;

  rv_alu u_alu (
    .a(op_a), .b(op_b), .op(ctrl.alu_op), .rs1_data, .rs2_data,
    .funct3(ctrl.funct3), .result(alu_out), .branch_taken
  );

  rv_data_mem u_data_mem (
    .clk, .addr(alu_out), .wdata(rs2_data), .funct3(ctrl.funct3),
    .ren(mem_phase && ctrl.mem_ren), .wen(wb_phase && ctrl.mem_wen), .rdata(mem_rdata)
  );

  // link value for jal and jalr
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_mem:      wb_data = mem_rdata;
      rv_pkg::wb_pc_plus4: wb_data = pc_plus4;
      default:             wb_data = alu_out;
    endcase
  end

  assign imem_addr = pc;

  assign retire.valid = retire_valid;
  assign retire.pc = pc;
  assign retire.instr = instr;
  assign retire.rd_wen = ctrl.reg_wen;
  assign retire.rd = ctrl.rd;
  assign retire.rd_data = wb_data;

endmodule

/* sim/rv_ref_model.sv */
module rv_ref_model;
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] regs [32];
  logic [7:0] mem [4*rv_pkg::dmem_words];
  logic [31:0] pc;
  bit halted;
  int count;

  task automatic reset();
    foreach (regs[i]) regs[i] = '0;
    foreach (mem[i]) mem[i] = '0;
    pc = rv_pkg::reset_pc;
    halted = 0;
    count = 0;
  endtask

  function automatic logic [31:0] alu(input logic [31:0] a, input logic [31:0] b,
                                      input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $unsigned($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction, architectural effect only
  task automatic step(input logic [31:0] ins, output logic wen, output logic [4:0] rd,
                      output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] next;
    logic [31:0] addr;
    logic [31:0] sh;
    logic [2:0] f3;
    logic [9:0] idx;
    logic [9:0] base;
    logic taken;
    f3 = ins[14:12];
    rd = ins[11:7];
    a = regs[ins[19:15]];
    b = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'd0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next = pc + 32'd4;
    wen = 1'b0;
    data = '0;
    addr = a + ((ins[6:0] == rv_pkg::op_store) ? imm_s : imm_i);
    idx = 10'(addr - rv_pkg::dmem_base);
    base = {idx[9:2], 2'b00};
    sh = {mem[base+3], mem[base+2], mem[base+1], mem[base]} >> (8 * idx[1:0]);
    case (ins[6:0])
      rv_pkg::op_lui: begin
        wen = 1'b1;
        data = imm_u;
      end
      rv_pkg::op_auipc: begin
        wen = 1'b1;
        data = pc + imm_u;
      end
      rv_pkg::op_jal: begin
        wen = 1'b1;
        data = pc + 32'd4;
        next = pc + imm_j;
      end
      rv_pkg::op_jalr: begin
        wen = 1'b1;
        data = pc + 32'd4;
        next = (a + imm_i) & ~32'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) next = pc + imm_b;
      end
      rv_pkg::op_load: begin
        wen = 1'b1;
        case (f3)
          3'd0: data = {{24{sh[7]}}, sh[7:0]};
          3'd1: data = {{16{sh[15]}}, sh[15:0]};
          3'd4: data = {24'd0, sh[7:0]};
          3'd5: data = {16'd0, sh[15:0]};
          default: data = sh;
        endcase
      end
      rv_pkg::op_store: begin
        mem[idx] = b[7:0];
        if (f3 != 3'd0) mem[idx+1] = b[15:8];
        if (f3 == 3'd2) begin
          mem[idx+2] = b[23:16];
          mem[idx+3] = b[31:24];
        end
      end
      rv_pkg::op_imm: begin
        wen = 1'b1;
        data = alu(a, imm_i, f3, f3 == 3'd5 && ins[30]);
      end
      rv_pkg::op_reg: begin
        wen = 1'b1;
        data = alu(a, b, f3, ins[30]);
      end
      rv_pkg::op_system: halted = 1;
      default: ;
    endcase
    if (wen && rd != 5'd0) regs[rd] = data;
    pc = next;
    count++;
  endtask

endmodule

/* sim/rv_core_tb.sv */
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 5000;
  localparam int prog_words = 512;
  localparam logic [31:0] ecall_word = 32'h0000_0073;
  localparam int t_reset = 0;
  localparam int t_alu = 1;
  localparam int t_mem = 2;
  localparam int t_flow = 3;
  localparam int t_x0 = 4;
  localparam int t_halt = 5;

  logic clk = 1'b0;
  logic arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] imem_off;
  rv_pkg::rv_retire_t retire;
  logic halted;

  logic [31:0] prog [prog_words];
  logic [31:0] seed;
  int n_words;
  string test_names [6] = '{"reset_timing", "alu_imm", "memory", "control_flow",
                            "x0_write", "halt"};
  int test_checks [6];
  int test_errs [6];
  int retire_count;
  bit timed_out;

  rv_core i_dut (.clk, .arst_n, .imem_addr, .imem_data, .retire, .halted);
  rv_ref_model ref_model ();

  always #5 clk = ~clk;

  // program memory answers in the same cycle
  assign imem_off = imem_addr - rv_pkg::reset_pc;
  assign imem_data = prog[imem_off[10:2]];

  // every retire pulse of the DUT, including any after the halt
  always @(negedge clk) begin
    if (arst_n && retire.valid) begin
      retire_count++;
    end
  end

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - rv_pkg::reset_pc;
    return prog[off[10:2]];
  endfunction

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  function automatic logic [4:0] pick_rd();
    if (rand_below(16) == 0) return 5'd0;
    return 5'(1 + rand_below(14));
  endfunction

  function automatic logic [4:0] pick_rs();
    return 5'(rand_below(16));
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[n_words] = w;
    n_words++;
  endtask

  task automatic emit_alu();
    logic [2:0] f3;
    logic [4:0] rd;
    logic alt;
    logic [11:0] imm;
    f3 = 3'(rand_below(8));
    rd = pick_rd();
    alt = (rand_below(2) == 1);
    if (rand_below(2) == 0) begin
      emit(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                 pick_rs(), pick_rs(), f3, rd));
    end else begin
      imm = 12'(next_rand());
      // shifts keep a legal funct7
      if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};
      emit(enc_i(imm, pick_rs(), f3, rd, rv_pkg::op_imm));
    end
  endtask

  // x15 holds dmem_base and offsets stay in the first 8 words
  task automatic emit_mem();
    logic [2:0] f3;
    logic [11:0] off;
    f3 = 3'(rand_below(3));
    off = 12'(rand_below(8) * 4);
    if (f3 == 3'd0) off += 12'(rand_below(4));
    else if (f3 == 3'd1) off += 12'(2 * rand_below(2));
    if (rand_below(2) == 0) begin
      emit(enc_s(off, pick_rs(), 5'd15, f3));
    end else begin
      if (f3 != 3'd2 && rand_below(2) == 1) f3 = f3 | 3'b100;
      emit(enc_i(off, 5'd15, f3, pick_rd(), rv_pkg::op_load));
    end
  endtask

  task automatic gen_program();
    int kind;
    int k;
    int tgt;
    logic [4:0] r;
    logic [2:0] f3;
    foreach (prog[i]) prog[i] = ecall_word;
    n_words = 0;
    seed = 32'h8fe3de49;
    emit(enc_u(rv_pkg::dmem_base[31:12], 5'd15, rv_pkg::op_lui));
    for (int w = 0; w < 8; w++) emit(enc_s(12'(4 * w), 5'd0, 5'd15, 3'b010));
    while (n_words < 380) begin
      kind = rand_below(10);
      // every jump skips exactly k plain ALU words
      k = rand_below(4);
      case (kind)
        0, 1, 2: emit_alu();
        3: emit(enc_u(20'(next_rand()), pick_rd(),
                      (rand_below(2) == 0) ? rv_pkg::op_lui : rv_pkg::op_auipc));
        4, 5: emit_mem();
        6, 7: begin
          f3 = 3'(rand_below(6));
          if (f3 >= 3'd2) f3 += 3'd2;
          emit(enc_b(13'(4 * (k + 1)), pick_rs(), pick_rs(), f3));
          repeat (k) emit_alu();
        end
        8: begin
          emit(enc_j(21'(4 * (k + 1)), pick_rd()));
          repeat (k) emit_alu();
        end
        default: begin
          r = 5'(1 + rand_below(14));
          // odd target checks that bit 0 is dropped
          tgt = 4 * (n_words + 3 + k) + rand_below(2);
          emit(enc_u(rv_pkg::reset_pc[31:12], r, rv_pkg::op_lui));
          emit(enc_i(12'(tgt), r, 3'd0, r, rv_pkg::op_imm));
          emit(enc_i(12'd0, r, 3'd0, pick_rd(), rv_pkg::op_jalr));
          repeat (k) emit_alu();
        end
      endcase
    end
    emit(ecall_word);
  endtask

  task automatic check(input int t, input string what, input logic [31:0] exp,
                       input logic [31:0] act);
    test_checks[t]++;
    if (exp !== act) begin
      test_errs[t]++;
      $display("error %s %s: expected %h, actual %h", test_names[t], what, exp, act);
    end
  endtask

  function automatic int test_of(input logic [31:0] ins, input logic wen,
                                 input logic [4:0] rd);
    if (wen && rd == 5'd0) return t_x0;
    case (ins[6:0])
      rv_pkg::op_load, rv_pkg::op_store: return t_mem;
      rv_pkg::op_branch, rv_pkg::op_jal, rv_pkg::op_jalr: return t_flow;
      rv_pkg::op_system: return t_halt;
      default: return t_alu;
    endcase
  endfunction

  task automatic wait_retire(output int cycles);
    @(negedge clk);
    cycles = 1;
    while (!retire.valid && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!retire.valid) begin
      timed_out = 1;
      $display("no retire pulse within %0d cycles", timeout_cycles);
    end
  endtask

  task automatic process_retire();
    logic [31:0] exp_pc;
    logic [31:0] ins;
    logic wen;
    logic [4:0] rd;
    logic [31:0] data;
    int t;
    exp_pc = ref_model.pc;
    ins = word_at(exp_pc);
    ref_model.step(ins, wen, rd, data);
    t = test_of(ins, wen, rd);
    check(t, "pc", exp_pc, retire.pc);
    check(t, "instr", ins, retire.instr);
    check(t, "rd_wen", 32'(wen), 32'(retire.rd_wen));
    if (wen) begin
      check(t, "rd", 32'(rd), 32'(retire.rd));
      check(t, "rd_data", data, retire.rd_data);
    end
  endtask

  initial begin
    int cycles;
    int extra;
    int errs;
    int checks;
    bit done;
    arst_n = 1'b0;
    timed_out = 0;
    retire_count = 0;
    gen_program();
    ref_model.reset();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check(t_reset, "halted", 32'd0, 32'(halted));
    check(t_reset, "retire valid", 32'd0, 32'(retire.valid));
    check(t_reset, "fetch address", rv_pkg::reset_pc, imem_addr);
    wait_retire(cycles);
    if (!timed_out) begin
      // release cycle is fetch, then mem, then wb
      check(t_reset, "cycles to first retire", 32'd2, 32'(cycles));
      check(t_reset, "first pc", rv_pkg::reset_pc, retire.pc);
    end
    done = 0;
    while (!timed_out && !done) begin
      process_retire();
      done = ref_model.halted;
      if (!done) begin
        wait_retire(cycles);
        if (!timed_out) check(t_reset, "retire spacing", 32'd3, 32'(cycles));
      end
    end
    if (!timed_out) begin
      cycles = 0;
      while (!halted && cycles < timeout_cycles) begin
        @(negedge clk);
        cycles++;
      end
      check(t_halt, "halted", 32'd1, 32'(halted));
      extra = 0;
      repeat (30) begin
        @(negedge clk);
        if (retire.valid) extra++;
      end
      check(t_halt, "retires after halt", 32'd0, 32'(extra));
      check(t_halt, "retire count", 32'(ref_model.count), 32'(retire_count));
    end
    errs = 0;
    checks = 0;
    for (int t = 0; t < 6; t++) begin
      $display("%s: %0d checks, %0d errors", test_names[t], test_checks[t], test_errs[t]);
      errs += test_errs[t];
      checks += test_checks[t];
    end
    $display("tests 6, checks %0d, errors %0d, retired %0d", checks, errs, retire_count);
    if (errs == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* rv_core.f */
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_imm_gen.sv
design/rv_data_mem.sv
design/rv_control.sv
design/rv_core.sv
sim/rv_ref_model.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = rv_core_tb
FILELIST  = rv_core.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
